// File: hdl/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// data word width
`define EX_XLEN 32

// one-hot alu op
`define EX_ALU_OP_W 12

// ex to mem bundle:
//   rf_we(1) rf_waddr(5) pc(32) result(32) mem_op(4) md_op(3) ale(1) offset(2)
`define EX_TO_MEM_WIDTH (1 + 5 + `EX_XLEN + `EX_XLEN + 4 + 3 + 1 + 2)

`endif

// File: hdl/ex_pkg.sv
`include "ex_params.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]     word_t;
    typedef logic [`EX_ALU_OP_W-1:0] alu_op_t;
    typedef logic [4:0]              reg_addr_t;
    typedef logic [3:0]              byte_en_t;
    typedef logic [2*`EX_XLEN-1:0]   dword_t;

    typedef enum logic [3:0] {
        mem_none, mem_ld_b, mem_ld_bu, mem_ld_h, mem_ld_hu,
        mem_ld_w, mem_st_b, mem_st_h, mem_st_w
    } mem_op_e;

    typedef enum logic [2:0] {
        md_none, md_mul_w, md_mulh_w, md_mulh_wu,
        md_div_w, md_mod_w, md_div_wu, md_mod_wu
    } md_op_e;

    typedef enum logic [1:0] {div_idle, div_busy, div_done} div_state_e;

endpackage

// File: hdl/alu.sv
module alu (
    input  ex_pkg::alu_op_t alu_op,
    input  ex_pkg::word_t   alu_src1,
    input  ex_pkg::word_t   alu_src2,
    output ex_pkg::word_t   alu_result
);
    logic          op_add, op_sub, op_slt, op_sltu;
    logic          op_and, op_nor, op_or, op_xor;
    logic          op_sll, op_srl, op_sra, op_lui;

    logic [32:0]   sum;
    ex_pkg::word_t slt_res, sltu_res, sra_res;
    logic [4:0]    shamt;

    assign {op_lui, op_sra, op_srl, op_sll,
            op_xor, op_or, op_nor, op_and,
            op_sltu, op_slt, op_sub, op_add} = alu_op;

    // sub and compares share the adder
    assign sum = {1'b0, alu_src1}
               + {1'b0, (op_sub | op_slt | op_sltu) ? ~alu_src2 : alu_src2}
               + {32'd0, op_sub | op_slt | op_sltu};

    assign slt_res  = {31'd0, (alu_src1[31] & ~alu_src2[31])
                            | (~(alu_src1[31] ^ alu_src2[31]) & sum[31])};
    // no carry out means src1 < src2
    assign sltu_res = {31'd0, ~sum[32]};

    assign shamt = alu_src2[4:0];

    // kept apart so the shift stays signed
    assign sra_res = $signed(alu_src1) >>> shamt;

    assign alu_result = ({32{op_add | op_sub}} & sum[31:0])
                      | ({32{op_slt}}          & slt_res)
                      | ({32{op_sltu}}         & sltu_res)
                      | ({32{op_and}}          & (alu_src1 & alu_src2))
                      | ({32{op_nor}}          & ~(alu_src1 | alu_src2))
                      | ({32{op_or}}           & (alu_src1 | alu_src2))
                      | ({32{op_xor}}          & (alu_src1 ^ alu_src2))
                      | ({32{op_sll}}          & (alu_src1 << shamt))
                      | ({32{op_srl}}          & (alu_src1 >> shamt))
                      | ({32{op_sra}}          & sra_res)
                      | ({32{op_lui}}          & alu_src2);

endmodule

// File: hdl/mul.sv
module mul (
    input  logic           clk,
    input  logic           en,
    input  logic           mul_signed,
    input  ex_pkg::word_t  x,
    input  ex_pkg::word_t  y,
    output ex_pkg::dword_t product
);
    logic signed [32:0] x_ext;
    logic signed [32:0] y_ext;
    logic signed [65:0] full;

    // one extra bit turns unsigned into signed
    assign x_ext = {mul_signed & x[31], x};
    assign y_ext = {mul_signed & y[31], y};
    assign full  = x_ext * y_ext;

    always_ff @(posedge clk) begin
        if (en) begin
            product <= full[63:0];
        end
    end

endmodule

// File: hdl/div.sv
module div (
    input  logic          clk,
    input  logic          resetn,
    input  logic          start,
    input  logic          cancel,
    input  logic          div_signed,
    input  ex_pkg::word_t x,
    input  ex_pkg::word_t y,
    output ex_pkg::word_t quotient,
    output ex_pkg::word_t remainder,
    output logic          complete
);
    ex_pkg::div_state_e state;
    logic [4:0]         step_cnt;
    ex_pkg::word_t      rem_q, quo_q, dvs_q;
    logic               neg_quo, neg_rem;
    ex_pkg::word_t      abs_x, abs_y;
    logic [32:0]        shifted;
    logic [33:0]        trial;

    assign abs_x = (div_signed && x[31]) ? -x : x;
    assign abs_y = (div_signed && y[31]) ? -y : y;

    // one restoring step
    assign shifted = {rem_q, quo_q[31]};
    assign trial   = {1'b0, shifted} - {2'b00, dvs_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= ex_pkg::div_idle;
            step_cnt <= 5'd0;
        end else if (cancel) begin
            state    <= ex_pkg::div_idle;
            step_cnt <= 5'd0;
        end else begin
            case (state)
                ex_pkg::div_idle: begin
                    if (start) begin
                        state    <= ex_pkg::div_busy;
                        step_cnt <= 5'd0;
                    end
                end
                ex_pkg::div_busy: begin
                    step_cnt <= step_cnt + 5'd1;
                    if (step_cnt == 5'd31) begin
                        state <= ex_pkg::div_done;
                    end
                end
                default: begin
                    if (!start) begin
                        state <= ex_pkg::div_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ex_pkg::div_idle && start) begin
            rem_q   <= '0;
            quo_q   <= abs_x;
            dvs_q   <= abs_y;
            neg_quo <= div_signed & (x[31] ^ y[31]);
            neg_rem <= div_signed & x[31];
        end else if (state == ex_pkg::div_busy) begin
            // borrow means restore
            rem_q <= trial[33] ? shifted[31:0] : trial[31:0];
            quo_q <= {quo_q[30:0], ~trial[33]};
        end
    end

    assign quotient  = neg_quo ? -quo_q : quo_q;
    assign remainder = neg_rem ? -rem_q : rem_q;
    assign complete  = (state == ex_pkg::div_done);

endmodule

// File: hdl/ex_stage.sv
`include "ex_params.svh"

module ex_stage (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        ex_flush,
    input  logic                        id_valid,
    output logic                        ex_allowin,
    input  ex_pkg::alu_op_t             id_alu_op,
    input  ex_pkg::word_t               id_src1,
    input  ex_pkg::word_t               id_src2,
    input  ex_pkg::word_t               id_rkd_value,
    input  ex_pkg::word_t               id_pc,
    input  logic                        id_rf_we,
    input  ex_pkg::reg_addr_t           id_rf_waddr,
    input  ex_pkg::mem_op_e             id_mem_op,
    input  ex_pkg::md_op_e              id_md_op,
    input  logic                        mem_allowin,
    output logic                        ex_to_mem_valid,
    output logic [`EX_TO_MEM_WIDTH-1:0] ex_to_mem_bus,
    output ex_pkg::dword_t              mul_product,
    output logic                        data_sram_en,
    output ex_pkg::byte_en_t            data_sram_we,
    output ex_pkg::word_t               data_sram_addr,
    output ex_pkg::word_t               data_sram_wdata
);
    logic              ex_valid;
    logic              ready_go;
    logic              handoff;

    ex_pkg::alu_op_t   alu_op_q;
    ex_pkg::word_t     src1_q, src2_q, rkd_q, pc_q;
    logic              rf_we_q;
    ex_pkg::reg_addr_t rf_waddr_q;
    ex_pkg::mem_op_e   mem_op_q;
    ex_pkg::md_op_e    md_op_q;

    ex_pkg::word_t     alu_result;
    ex_pkg::word_t     div_quo, div_rem, ex_result;
    logic              is_div, is_mod, div_signed, div_complete;
    logic              is_load, is_store, is_half, is_word, ale;
    logic [1:0]        offset;
    ex_pkg::byte_en_t  st_be;

    assign is_div = md_op_q inside {ex_pkg::md_div_w, ex_pkg::md_mod_w,
                                    ex_pkg::md_div_wu, ex_pkg::md_mod_wu};
    assign is_mod     = md_op_q inside {ex_pkg::md_mod_w, ex_pkg::md_mod_wu};
    assign div_signed = md_op_q inside {ex_pkg::md_div_w, ex_pkg::md_mod_w};

    assign ready_go        = ~is_div | div_complete;
    assign ex_allowin      = ~ex_valid | (ready_go & mem_allowin) | ex_flush;
    assign ex_to_mem_valid = ex_valid & ready_go & ~ex_flush;
    assign handoff         = ex_to_mem_valid & mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid && ex_allowin) begin
            alu_op_q   <= id_alu_op;
            src1_q     <= id_src1;
            src2_q     <= id_src2;
            rkd_q      <= id_rkd_value;
            pc_q       <= id_pc;
            rf_we_q    <= id_rf_we;
            rf_waddr_q <= id_rf_waddr;
            mem_op_q   <= id_mem_op;
            md_op_q    <= id_md_op;
        end
    end

    alu u_alu (
        .alu_op     (alu_op_q),
        .alu_src1   (src1_q),
        .alu_src2   (src2_q),
        .alu_result (alu_result)
    );

    // product lands as the item enters mem
    mul u_mul (
        .clk        (clk),
        .en         (handoff),
        .mul_signed (md_op_q != ex_pkg::md_mulh_wu),
        .x          (src1_q),
        .y          (src2_q),
        .product    (mul_product)
    );

    // handing off a divide also clears the done state for the next one
    div u_div (
        .clk        (clk),
        .resetn     (resetn),
        .start      (ex_valid & is_div),
        .cancel     (ex_flush | (handoff & is_div)),
        .div_signed (div_signed),
        .x          (src1_q),
        .y          (src2_q),
        .quotient   (div_quo),
        .remainder  (div_rem),
        .complete   (div_complete)
    );

    assign ex_result = is_div ? (is_mod ? div_rem : div_quo) : alu_result;

    // memory access decode
    assign offset   = alu_result[1:0];
    assign is_load  = mem_op_q inside {ex_pkg::mem_ld_b, ex_pkg::mem_ld_bu, ex_pkg::mem_ld_h,
                                       ex_pkg::mem_ld_hu, ex_pkg::mem_ld_w};
    assign is_store = mem_op_q inside {ex_pkg::mem_st_b, ex_pkg::mem_st_h, ex_pkg::mem_st_w};
    assign is_half  = mem_op_q inside {ex_pkg::mem_ld_h, ex_pkg::mem_ld_hu, ex_pkg::mem_st_h};
    assign is_word  = mem_op_q inside {ex_pkg::mem_ld_w, ex_pkg::mem_st_w};
    assign ale      = (is_half & offset[0]) | (is_word & (|offset));

    always_comb begin
        case (mem_op_q)
            ex_pkg::mem_st_b: st_be = 4'b0001 << offset;
            ex_pkg::mem_st_h: st_be = offset[1] ? 4'b1100 : 4'b0011;
            ex_pkg::mem_st_w: st_be = 4'b1111;
            default:          st_be = 4'b0000;
        endcase
    end

    assign data_sram_en    = handoff & (is_load | is_store) & ~ale;
    assign data_sram_we    = {4{data_sram_en}} & st_be;
    assign data_sram_addr  = {alu_result[31:2], 2'b00};
    assign data_sram_wdata = (mem_op_q == ex_pkg::mem_st_b) ? {4{rkd_q[7:0]}}  :
                             (mem_op_q == ex_pkg::mem_st_h) ? {2{rkd_q[15:0]}} :
                                                              rkd_q;

    assign ex_to_mem_bus = {rf_we_q, rf_waddr_q, pc_q, ex_result,
                            mem_op_q, md_op_q, ale, offset};

endmodule

// File: hdl/mem_stage.sv
`include "ex_params.svh"

module mem_stage (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        ex_to_mem_valid,
    input  logic [`EX_TO_MEM_WIDTH-1:0] ex_to_mem_bus,
    output logic                        mem_allowin,
    input  ex_pkg::dword_t              mul_product,
    input  ex_pkg::word_t               data_sram_rdata,
    input  logic                        wb_allowin,
    output logic                        wb_valid,
    output ex_pkg::word_t               wb_pc,
    output ex_pkg::word_t               wb_rf_wdata,
    output logic                        wb_rf_we,
    output ex_pkg::reg_addr_t           wb_rf_waddr,
    output logic                        wb_ale
);
    logic                        mem_valid;
    logic                        mem_first;
    logic [`EX_TO_MEM_WIDTH-1:0] bus_q;
    ex_pkg::word_t               rdata_q, load_word, shifted, load_data, result;
    logic                        rf_we;
    logic [3:0]                  mem_op_bits;
    logic [2:0]                  md_op_bits;
    logic                        ale;
    logic [1:0]                  offset;
    ex_pkg::mem_op_e             mem_op;
    ex_pkg::md_op_e              md_op;

    assign mem_allowin = ~mem_valid | wb_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
            mem_first <= 1'b0;
        end else begin
            if (mem_allowin) begin
                mem_valid <= ex_to_mem_valid;
            end
            mem_first <= ex_to_mem_valid & mem_allowin;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            bus_q <= ex_to_mem_bus;
        end
    end

    // sram data is only valid the first cycle, keep it for stalls
    always_ff @(posedge clk) begin
        if (mem_first) begin
            rdata_q <= data_sram_rdata;
        end
    end

    assign {rf_we, wb_rf_waddr, wb_pc, result, mem_op_bits, md_op_bits, ale, offset} = bus_q;
    assign mem_op = ex_pkg::mem_op_e'(mem_op_bits);
    assign md_op  = ex_pkg::md_op_e'(md_op_bits);

    assign load_word = mem_first ? data_sram_rdata : rdata_q;
    assign shifted   = load_word >> {offset, 3'b000};

    always_comb begin
        case (mem_op)
            ex_pkg::mem_ld_b:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            ex_pkg::mem_ld_bu: load_data = {24'd0, shifted[7:0]};
            ex_pkg::mem_ld_h:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            ex_pkg::mem_ld_hu: load_data = {16'd0, shifted[15:0]};
            ex_pkg::mem_ld_w:  load_data = load_word;
            default:           load_data = result;
        endcase
    end

    always_comb begin
        case (md_op)
            ex_pkg::md_mul_w:   wb_rf_wdata = mul_product[31:0];
            ex_pkg::md_mulh_w,
            ex_pkg::md_mulh_wu: wb_rf_wdata = mul_product[63:32];
            default:            wb_rf_wdata = load_data;
        endcase
    end

    assign wb_valid = mem_valid;
    assign wb_rf_we = rf_we & ~ale;
    assign wb_ale   = ale;

endmodule

// File: hdl/ex_mem_top.sv
`include "ex_params.svh"

module ex_mem_top (
    input  logic              clk,
    input  logic              resetn,
    input  logic              ex_flush,
    input  logic              id_valid,
    output logic              ex_allowin,
    input  ex_pkg::alu_op_t   id_alu_op,
    input  ex_pkg::word_t     id_src1,
    input  ex_pkg::word_t     id_src2,
    input  ex_pkg::word_t     id_rkd_value,
    input  ex_pkg::word_t     id_pc,
    input  logic              id_rf_we,
    input  ex_pkg::reg_addr_t id_rf_waddr,
    input  ex_pkg::mem_op_e   id_mem_op,
    input  ex_pkg::md_op_e    id_md_op,
    output logic              data_sram_en,
    output ex_pkg::byte_en_t  data_sram_we,
    output ex_pkg::word_t     data_sram_addr,
    output ex_pkg::word_t     data_sram_wdata,
    input  ex_pkg::word_t     data_sram_rdata,
    input  logic              wb_allowin,
    output logic              wb_valid,
    output ex_pkg::word_t     wb_pc,
    output ex_pkg::word_t     wb_rf_wdata,
    output logic              wb_rf_we,
    output ex_pkg::reg_addr_t wb_rf_waddr,
    output logic              wb_ale
);
    logic                        mem_allowin;
    logic                        ex_to_mem_valid;
    logic [`EX_TO_MEM_WIDTH-1:0] ex_to_mem_bus;
    ex_pkg::dword_t              mul_product;

    ex_stage u_ex_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ex_flush        (ex_flush),
        .id_valid        (id_valid),
        .ex_allowin      (ex_allowin),
        .id_alu_op       (id_alu_op),
        .id_src1         (id_src1),
        .id_src2         (id_src2),
        .id_rkd_value    (id_rkd_value),
        .id_pc           (id_pc),
        .id_rf_we        (id_rf_we),
        .id_rf_waddr     (id_rf_waddr),
        .id_mem_op       (id_mem_op),
        .id_md_op        (id_md_op),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem_bus   (ex_to_mem_bus),
        .mul_product     (mul_product),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem_bus   (ex_to_mem_bus),
        .mem_allowin     (mem_allowin),
        .mul_product     (mul_product),
        .data_sram_rdata (data_sram_rdata),
        .wb_allowin      (wb_allowin),
        .wb_valid        (wb_valid),
        .wb_pc           (wb_pc),
        .wb_rf_wdata     (wb_rf_wdata),
        .wb_rf_we        (wb_rf_we),
        .wb_rf_waddr     (wb_rf_waddr),
        .wb_ale          (wb_ale)
    );

endmodule

// File: dv/ex_mem_assertions.sv
`include "ex_params.svh"

module ex_mem_assertions (
    input logic                        clk,
    input logic                        resetn,
    input logic                        ex_flush,
    input logic                        data_sram_en,
    input ex_pkg::byte_en_t            data_sram_we,
    input logic                        ex_to_mem_valid,
    input logic                        mem_allowin,
    input logic [`EX_TO_MEM_WIDTH-1:0] ex_to_mem_bus
);
    timeunit 1ns;
    timeprecision 1ps;

    ex_pkg::mem_op_e bus_mem_op;
    logic [1:0]      bus_offset;
    logic            bus_load, bus_store, bus_aligned;

    // mem_op and offset sit in the low bits of the bundle
    assign bus_mem_op  = ex_pkg::mem_op_e'(ex_to_mem_bus[9:6]);
    assign bus_offset  = ex_to_mem_bus[1:0];
    assign bus_load    = bus_mem_op inside {ex_pkg::mem_ld_b, ex_pkg::mem_ld_bu,
                                            ex_pkg::mem_ld_h, ex_pkg::mem_ld_hu,
                                            ex_pkg::mem_ld_w};
    assign bus_store   = bus_mem_op inside {ex_pkg::mem_st_b, ex_pkg::mem_st_h,
                                            ex_pkg::mem_st_w};
    assign bus_aligned = (bus_mem_op inside {ex_pkg::mem_ld_b, ex_pkg::mem_ld_bu,
                                             ex_pkg::mem_st_b})
                       || (bus_offset == 2'b00)
                       || (bus_offset == 2'b10 && bus_mem_op inside {ex_pkg::mem_ld_h,
                                                                    ex_pkg::mem_ld_hu,
                                                                    ex_pkg::mem_st_h});

    // sram request only on an aligned load or store handoff
    sram_en_on_handoff: assert property (@(posedge clk) disable iff (!resetn)
        data_sram_en |-> ex_to_mem_valid && mem_allowin && bus_aligned
                         && (bus_load ? (data_sram_we == 4'b0000)
                                      : (bus_store && data_sram_we != 4'b0000)))
        else $error("data_sram_en outside an aligned memory handoff");

    held_item_stable: assert property (@(posedge clk) disable iff (!resetn)
        ex_to_mem_valid && !mem_allowin && !ex_flush |=> $stable(ex_to_mem_bus))
        else $error("execute item changed while stalled");

    sram_idle_after_reset: assert property (@(posedge clk) !resetn |=> !data_sram_en)
        else $error("data_sram_en high after reset");

endmodule

bind ex_stage ex_mem_assertions u_assert (
    .clk             (clk),
    .resetn          (resetn),
    .ex_flush        (ex_flush),
    .data_sram_en    (data_sram_en),
    .data_sram_we    (data_sram_we),
    .ex_to_mem_valid (ex_to_mem_valid),
    .mem_allowin     (mem_allowin),
    .ex_to_mem_bus   (ex_to_mem_bus)
);

// File: dv/ex_mem_tb.sv
module ex_mem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        ex_pkg::word_t     pc;
        logic              we;
        ex_pkg::reg_addr_t waddr;
        ex_pkg::word_t     data;
        logic              ale;
    } exp_t;

    logic clk, resetn, ex_flush, id_valid, ex_allowin, id_rf_we, wb_allowin;
    ex_pkg::alu_op_t   id_alu_op;
    ex_pkg::word_t     id_src1, id_src2, id_rkd_value, id_pc;
    ex_pkg::reg_addr_t id_rf_waddr, wb_rf_waddr;
    ex_pkg::mem_op_e   id_mem_op;
    ex_pkg::md_op_e    id_md_op;
    logic              data_sram_en, wb_valid, wb_rf_we, wb_ale;
    ex_pkg::byte_en_t  data_sram_we;
    ex_pkg::word_t     data_sram_addr, data_sram_wdata, data_sram_rdata, wb_pc, wb_rf_wdata;

    ex_pkg::word_t sram [64];
    ex_pkg::word_t shadow [64];
    exp_t          exp_q [$];
    exp_t          head;
    integer        seed;
    logic          bp_on;
    ex_pkg::word_t pc_cnt;

    ex_mem_top dut0 (.*);

    always #50 clk = ~clk;

    // sram model with one cycle read
    always @(posedge clk) begin
        if (data_sram_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_sram_we[b]) begin
                    sram[data_sram_addr[7:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                end
            end
            data_sram_rdata <= sram[data_sram_addr[7:2]];
        end
    end

    always @(posedge clk) begin
        if (bp_on) wb_allowin <= ($random(seed) & 3) != 0;
        else wb_allowin <= 1'b1;
    end

    task automatic fail_now();
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(string name, ex_pkg::word_t got, ex_pkg::word_t want);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
        fail_now();
    endtask

    function automatic logic ref_ale(ex_pkg::mem_op_e mop, ex_pkg::word_t addr);
        logic half, word;
        half = mop inside {ex_pkg::mem_ld_h, ex_pkg::mem_ld_hu, ex_pkg::mem_st_h};
        word = mop inside {ex_pkg::mem_ld_w, ex_pkg::mem_st_w};
        return (half & addr[0]) | (word & (addr[1:0] != 2'b00));
    endfunction

    function automatic ex_pkg::word_t ref_result(ex_pkg::alu_op_t op, ex_pkg::word_t a,
            ex_pkg::word_t b, ex_pkg::mem_op_e mop, ex_pkg::md_op_e dop);
        ex_pkg::word_t      sum, w, sh, ax, ay, qm, rm;
        logic signed [63:0] p;
        logic [63:0]        up;
        logic               sgn;
        sum = a + b;
        w = shadow[sum[7:2]];
        sh = w >> (8 * sum[1:0]);
        case (mop)
            ex_pkg::mem_ld_b:  return {{24{sh[7]}}, sh[7:0]};
            ex_pkg::mem_ld_bu: return {24'd0, sh[7:0]};
            ex_pkg::mem_ld_h:  return {{16{sh[15]}}, sh[15:0]};
            ex_pkg::mem_ld_hu: return {16'd0, sh[15:0]};
            ex_pkg::mem_ld_w:  return w;
            ex_pkg::mem_none:  ;
            default:           return sum;
        endcase
        p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up = {32'd0, a} * {32'd0, b};
        sgn = dop inside {ex_pkg::md_div_w, ex_pkg::md_mod_w};
        ax = (sgn && a[31]) ? -a : a;
        ay = (sgn && b[31]) ? -b : b;
        qm = (ay == 0) ? 32'hffff_ffff : ax / ay;
        rm = (ay == 0) ? ax : ax % ay;
        if (sgn && (a[31] ^ b[31])) qm = -qm;
        if (sgn && a[31]) rm = -rm;
        case (dop)
            ex_pkg::md_mul_w:                     return p[31:0];
            ex_pkg::md_mulh_w:                    return p[63:32];
            ex_pkg::md_mulh_wu:                   return up[63:32];
            ex_pkg::md_div_w, ex_pkg::md_div_wu:  return qm;
            ex_pkg::md_mod_w, ex_pkg::md_mod_wu:  return rm;
            default:                              ;
        endcase
        case (op)
            12'h001: return a + b;
            12'h002: return a - b;
            12'h004: return {31'd0, $signed(a) < $signed(b)};
            12'h008: return {31'd0, a < b};
            12'h010: return a & b;
            12'h020: return ~(a | b);
            12'h040: return a | b;
            12'h080: return a ^ b;
            12'h100: return a << b[4:0];
            12'h200: return a >> b[4:0];
            12'h400: return $signed(a) >>> b[4:0];
            default: return b;
        endcase
    endfunction

    // called on a rising edge, returns on the accepting edge
    task automatic send(ex_pkg::alu_op_t op, ex_pkg::word_t a, ex_pkg::word_t b,
            ex_pkg::word_t rkd, logic we, ex_pkg::mem_op_e mop, ex_pkg::md_op_e dop);
        exp_t          e;
        ex_pkg::word_t addr;
        int            n;
        e.pc = pc_cnt;
        e.waddr = $random(seed);
        id_valid <= 1'b1;
        id_alu_op <= op;
        id_src1 <= a;
        id_src2 <= b;
        id_rkd_value <= rkd;
        id_pc <= pc_cnt;
        id_rf_we <= we;
        id_rf_waddr <= e.waddr;
        id_mem_op <= mop;
        id_md_op <= dop;
        pc_cnt += 4;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 200) begin
                $display("ex_allowin stayed low for 200 cycles at %0t", $time);
                fail_now();
            end
        end while (!ex_allowin);
        addr = a + b;
        e.ale = ref_ale(mop, addr);
        e.we = we & ~e.ale;
        e.data = ref_result(op, a, b, mop, dop);
        exp_q.push_back(e);
        if (!e.ale) begin
            for (int k = 0; k < 4; k++) begin
                if ((mop == ex_pkg::mem_st_w) ||
                    (mop == ex_pkg::mem_st_h && k[1] == addr[1]) ||
                    (mop == ex_pkg::mem_st_b && k[1:0] == addr[1:0]))
                    shadow[addr[7:2]][8*k +: 8] = rkd[8*(k % ((mop == ex_pkg::mem_st_b) ? 1 :
                        (mop == ex_pkg::mem_st_h) ? 2 : 4)) +: 8];
            end
        end
    endtask

    always @(posedge clk) begin
        if (resetn && wb_valid && wb_allowin) begin
            if (exp_q.size() == 0) begin
                $display("unexpected write-back at %0t", $time);
                fail_now();
            end
            head = exp_q.pop_front();
            assert (wb_pc === head.pc) else report_mismatch("wb_pc", wb_pc, head.pc);
            assert (wb_rf_we === head.we) else report_mismatch("wb_rf_we", wb_rf_we, head.we);
            assert (wb_rf_waddr === head.waddr)
                else report_mismatch("wb_rf_waddr", wb_rf_waddr, head.waddr);
            assert (wb_ale === head.ale) else report_mismatch("wb_ale", wb_ale, head.ale);
            assert (head.ale || wb_rf_wdata === head.data)
                else report_mismatch("wb_rf_wdata", wb_rf_wdata, head.data);
        end
    end

    initial begin
        ex_pkg::word_t ops [8];
        int            n;
        seed = 51;
        clk = 0;
        resetn = 0;
        ex_flush = 0;
        id_valid = 0;
        id_alu_op = '0;
        id_src1 = '0;
        id_src2 = '0;
        id_rkd_value = '0;
        id_pc = '0;
        id_rf_we = 0;
        id_rf_waddr = '0;
        id_mem_op = ex_pkg::mem_none;
        id_md_op = ex_pkg::md_none;
        wb_allowin = 1;
        data_sram_rdata = '0;
        bp_on = 0;
        pc_cnt = 32'h1c00_0000;
        for (int i = 0; i < 64; i++) begin
            sram[i] = (i * 32'h9e37_79b9) ^ {i[7:0], ~i[7:0], i[7:0], 8'h5a};
            shadow[i] = sram[i];
        end
        ops = '{32'd0, 32'd7, 32'hffff_fff9, 32'h8000_0000, 32'h7fff_ffff,
                32'hffff_ffff, 32'd3, 32'h1234_5678};
        repeat (16) @(posedge clk);
        resetn <= 1;
        @(posedge clk);
        for (int i = 0; i < 48; i++)
            send(12'h001 << ($unsigned($random(seed)) % 12), $random(seed), $random(seed), 0, 1,
                 ex_pkg::mem_none, ex_pkg::md_none);
        bp_on <= 1'b1;
        for (int d = 1; d < 8; d++) begin
            for (int i = 0; i < 8; i++)
                send(12'h001, ops[i], ops[(i * 3 + d) % 8], 0, 1, ex_pkg::mem_none,
                     ex_pkg::md_op_e'(d));
        end
        // stores at legal offsets, each read back by every load kind
        for (int s = 0; s < 7; s++) begin
            send(12'h001, 32'h40, (s < 4) ? s : (s < 6) ? 2 * (s - 4) : 0, $random(seed), 0,
                 (s < 4) ? ex_pkg::mem_st_b : (s < 6) ? ex_pkg::mem_st_h : ex_pkg::mem_st_w,
                 ex_pkg::md_none);
            for (int o = 0; o < 4; o++) begin
                send(12'h001, 32'h40, o, 0, 1, ex_pkg::mem_ld_b, ex_pkg::md_none);
                send(12'h001, 32'h40, o, 0, 1, ex_pkg::mem_ld_bu, ex_pkg::md_none);
                send(12'h001, 32'h40, o & 2, 0, 1, ex_pkg::mem_ld_h, ex_pkg::md_none);
                send(12'h001, 32'h40, o & 2, 0, 1, ex_pkg::mem_ld_hu, ex_pkg::md_none);
            end
            send(12'h001, 32'h40, 0, 0, 1, ex_pkg::mem_ld_w, ex_pkg::md_none);
        end
        // misaligned accesses
        for (int o = 1; o < 4; o++) begin
            send(12'h001, 32'h44, o, 32'hdead_beef, 0, ex_pkg::mem_st_w, ex_pkg::md_none);
            send(12'h001, 32'h44, o, 32'hcafe_f00d, 0, ex_pkg::mem_st_h, ex_pkg::md_none);
            send(12'h001, 32'h44, o, 0, 1, ex_pkg::mem_ld_w, ex_pkg::md_none);
            send(12'h001, 32'h44, o, 0, 1, ex_pkg::mem_ld_h, ex_pkg::md_none);
            send(12'h001, 32'h44, 0, 0, 1, ex_pkg::mem_ld_w, ex_pkg::md_none);
        end
        // flush a running divide
        for (int i = 0; i < 3; i++) begin
            send(12'h001, $random(seed), $random(seed), 0, 1, ex_pkg::mem_none, ex_pkg::md_div_w);
            id_valid <= 1'b0;
            repeat (5) @(posedge clk);
            ex_flush <= 1'b1;
            @(posedge clk);
            ex_flush <= 1'b0;
            void'(exp_q.pop_back());
            send(12'h040, $random(seed), $random(seed), 0, 1, ex_pkg::mem_none, ex_pkg::md_none);
            send(12'h001, $random(seed), $random(seed), 0, 1, ex_pkg::mem_none, ex_pkg::md_mul_w);
        end
        id_valid <= 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < 500) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("%0d results never arrived within 500 cycles", exp_q.size());
            fail_now();
        end
    end

endmodule

// File: list.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/alu.sv
hdl/mul.sv
hdl/div.sv
hdl/ex_stage.sv
hdl/mem_stage.sv
hdl/ex_mem_top.sv
dv/ex_mem_assertions.sv
dv/ex_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ex/mem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module ex_mem_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vex_mem_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASS" sim.log; then
    exit 0
fi
exit 1
